//--- Bender.yml
package:
  name: rv_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/rv_core_pkg.sv
      - verilog/rv_fetch.sv
      - verilog/rv_decode.sv
      - verilog/rv_exec.sv
      - verilog/rv_writeback.sv
      - verilog/rv_mem_arbiter.sv
      - verilog/rv_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/rv_core_assert.sv
      - bench/rv_core_check.sv
      - bench/rv_core_tb.sv

//--- bench/rv_core_assert.sv
`timescale 1ns/1ps

module rv_core_assert (
    input logic       clk,
    input logic       rst,
    input logic [1:0] req,
    input logic [1:0] ready,
    input logic [3:0] wes
);

int error_count = 0;

// Fetch only ever reads, so every write is exec's, in the cycle before its answer.
a_fetch_no_write: assert property (@(posedge clk) disable iff (rst)
    wes != 4'b0000 |-> req[1] && !ready[1])
    else begin
        $error("Write strobe seen outside a pending exec request");
        error_count++;
    end

a_ready_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(ready))
    else begin
        $error("Both clients were answered in the same cycle");
        error_count++;
    end

a_wes_legal: assert property (@(posedge clk) disable iff (rst)
    wes inside {4'h0, 4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hc, 4'hf})
    else begin
        $error("Illegal byte strobe pattern %h", wes);
        error_count++;
    end

a_req0_held: assert property (@(posedge clk) disable iff (rst) req[0] && !ready[0] |=> req[0])
    else begin
        $error("Fetch dropped its request before ready");
        error_count++;
    end

a_req1_held: assert property (@(posedge clk) disable iff (rst) req[1] && !ready[1] |=> req[1])
    else begin
        $error("Exec dropped its request before ready");
        error_count++;
    end

endmodule

bind rv_mem_arbiter rv_core_assert i_assert (
    .clk(clk),
    .rst(rst),
    .req(req),
    .ready(ready),
    .wes(wes)
);

//--- bench/rv_core_check.sv
`timescale 1ns/1ps

module rv_core_check (
    input  logic        clk,
    input  logic        rst,
    input  logic [29:0] addr,
    input  logic [3:0]  wes,
    input  logic [31:0] data_out,
    output logic        done,
    output int          pass_count,
    output int          fail_count
);

// Each test ends with a store of its number to this address.
localparam logic [31:0] MARKER_ADDR = 32'h0000_03f8;

logic [31:0] exp_addr [$];
logic [31:0] exp_data [$];
logic [3:0]  exp_wes [$];
logic [31:0] end_addr;
int          test_errors;
int          test_stores;

function automatic void load_expectations();
    int          fd;
    int          n;
    string       line;
    string       tag;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] w;
    fd = $fopen("bench/rv_core_golden.txt", "r");
    if (fd == 0) begin
        $display("Cannot open the golden file for the store expectations");
        fail_count++;
        return;
    end
    while ($fgets(line, fd) > 0) begin
        n = $sscanf(line, "%s %h %h %h", tag, a, d, w);
        if (n >= 4 && tag == "S") begin
            exp_addr.push_back(a);
            exp_data.push_back(d);
            exp_wes.push_back(w[3:0]);
        end else if (n >= 2 && tag == "E") begin
            end_addr = a;
        end
    end
    $fclose(fd);
endfunction

task automatic compare_store();
    logic [31:0] ea;
    logic [31:0] ed;
    logic [3:0]  ew;
    int          errs;
    errs = 0;
    if (exp_addr.size() == 0) begin
        $display("Unexpected store to 0x%h with data 0x%h", {addr, 2'b00}, data_out);
        fail_count++;
        test_errors++;
    end else begin
        ea = exp_addr.pop_front();
        ed = exp_data.pop_front();
        ew = exp_wes.pop_front();
        if (addr !== ea[31:2]) begin
            $display("Fail addr: expected %h, got %h", ea[31:2], addr);
            errs++;
        end
        if (wes !== ew) begin
            $display("Fail wes: expected %h, got %h", ew, wes);
            errs++;
        end
        if (data_out !== ed) begin
            $display("Fail data_out: expected %h, got %h", ed, data_out);
            errs++;
        end
        if (errs == 0)
            pass_count++;
        else
            fail_count += errs;
        test_errors += errs;
        test_stores++;
        if (ea == MARKER_ADDR) begin
            $display("Test %0d done: %0d stores checked, %0d errors", ed, test_stores,
                     test_errors);
            test_errors = 0;
            test_stores = 0;
        end
    end
endtask

initial begin
    done        = 1'b0;
    pass_count  = 0;
    fail_count  = 0;
    test_errors = 0;
    test_stores = 0;
    end_addr    = 32'h0000_03fc;
    load_expectations();
end

// Outputs settle after the rising edge, so they are sampled on the falling one.
always @(negedge clk) begin
    if (!rst && wes != 4'b0000 && !done) begin
        if ({addr, 2'b00} == end_addr) begin
            if (exp_addr.size() != 0) begin
                $display("%0d expected stores never arrived", exp_addr.size());
                fail_count += exp_addr.size();
            end
            done = 1'b1;
        end else begin
            compare_store();
        end
    end
end

endmodule

//--- bench/rv_core_golden.txt
# P addr word = program word, D addr word = preloaded data word,
# S addr data wes = expected store (byte address), E addr = end-marker store.
P 00000000 FFB00093
P 00000004 00300113
P 00000008 402081B3
P 0000000C 4020D233
P 00000010 0020A2B3
P 00000014 0020B333
P 00000018 4010D393
P 0000001C 20302023
P 00000020 20402223
P 00000024 20502423
P 00000028 20602623
P 0000002C 20702823
P 00000030 00100F93
P 00000034 3FF02C23
P 00000038 12345437
P 0000003C 00001497
P 00000040 20802A23
P 00000044 20902C23
P 00000048 00200F93
P 0000004C 3FF02C23
P 00000050 00208463
P 00000054 00150513
P 00000058 00210463
P 0000005C 00158593
P 00000060 00209463
P 00000064 00158593
P 00000068 00211463
P 0000006C 00150513
P 00000070 0020C463
P 00000074 00158593
P 00000078 00114463
P 0000007C 00150513
P 00000080 0020D463
P 00000084 00150513
P 00000088 00115463
P 0000008C 00158593
P 00000090 0020E463
P 00000094 00150513
P 00000098 00116463
P 0000009C 00158593
P 000000A0 0020F463
P 000000A4 00158593
P 000000A8 00117463
P 000000AC 00150513
P 000000B0 0080066F
P 000000B4 00158593
P 000000B8 00C606E7
P 000000BC 00158593
P 000000C0 20A02E23
P 000000C4 22B02023
P 000000C8 22C02223
P 000000CC 22D02423
P 000000D0 00300F93
P 000000D4 3FF02C23
P 000000D8 30000703
P 000000DC 22E02623
P 000000E0 30100703
P 000000E4 22E02823
P 000000E8 30200703
P 000000EC 22E02A23
P 000000F0 30300703
P 000000F4 22E02C23
P 000000F8 30004703
P 000000FC 22E02E23
P 00000100 30104703
P 00000104 24E02023
P 00000108 30204703
P 0000010C 24E02223
P 00000110 30304703
P 00000114 24E02423
P 00000118 30001703
P 0000011C 24E02623
P 00000120 30201703
P 00000124 24E02823
P 00000128 30005703
P 0000012C 24E02A23
P 00000130 30205703
P 00000134 24E02C23
P 00000138 00400F93
P 0000013C 3FF02C23
P 00000140 26900023
P 00000144 269000A3
P 00000148 26900123
P 0000014C 269001A3
P 00000150 26901223
P 00000154 26901323
P 00000158 00500F93
P 0000015C 3FF02C23
P 00000160 00500013
P 00000164 26002423
P 00000168 00600F93
P 0000016C 3FF02C23
P 00000170 3E002E23
P 00000174 0000006F
D 00000300 80F17F82
S 00000200 FFFFFFF8 F
S 00000204 FFFFFFFF F
S 00000208 00000001 F
S 0000020C 00000000 F
S 00000210 FFFFFFFD F
S 000003F8 00000001 F
S 00000214 12345000 F
S 00000218 0000103C F
S 000003F8 00000002 F
S 0000021C 00000006 F
S 00000220 00000000 F
S 00000224 000000B4 F
S 00000228 000000BC F
S 000003F8 00000003 F
S 0000022C FFFFFF82 F
S 00000230 0000007F F
S 00000234 FFFFFFF1 F
S 00000238 FFFFFF80 F
S 0000023C 00000082 F
S 00000240 0000007F F
S 00000244 000000F1 F
S 00000248 00000080 F
S 0000024C 00007F82 F
S 00000250 FFFF80F1 F
S 00000254 00007F82 F
S 00000258 000080F1 F
S 000003F8 00000004 F
S 00000260 3C3C3C3C 1
S 00000261 3C3C3C3C 2
S 00000262 3C3C3C3C 4
S 00000263 3C3C3C3C 8
S 00000264 103C103C 3
S 00000266 103C103C C
S 000003F8 00000005 F
S 00000268 00000000 F
S 000003F8 00000006 F
E 000003FC

//--- bench/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

localparam int MEM_WORDS       = 256;
localparam int CYCLES_PER_INST = 200;

logic        clk;
logic        rst;
logic [31:0] data_in;
logic [31:0] data_out;
logic [29:0] addr;
logic [3:0]  wes;
logic [31:0] mem [MEM_WORDS];
int          prog_words;
logic        loaded;
logic        done;
int          pass_count;
int          fail_count;
int          total_fails;

rv_core i_dut (
    .clk(clk),
    .rst(rst),
    .data_in(data_in),
    .data_out(data_out),
    .addr(addr),
    .wes(wes)
);

rv_core_check i_check (
    .clk(clk),
    .rst(rst),
    .addr(addr),
    .wes(wes),
    .data_out(data_out),
    .done(done),
    .pass_count(pass_count),
    .fail_count(fail_count)
);

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

// Word memory: reads return one clock later, writes take the enabled lanes.
always @(posedge clk) begin
    data_in <= mem[addr[7:0]];
    for (int b = 0; b < 4; b++) begin
        if (wes[b])
            mem[addr[7:0]][8*b +: 8] <= data_out[8*b +: 8];
    end
end

function automatic bit load_image();
    int          fd;
    int          n;
    string       line;
    string       tag;
    logic [31:0] a;
    logic [31:0] d;
    for (int i = 0; i < MEM_WORDS; i++)
        mem[i] = 32'hbad0_0000 + (i << 2);
    fd = $fopen("bench/rv_core_golden.txt", "r");
    if (fd == 0)
        return 1'b0;
    while ($fgets(line, fd) > 0) begin
        n = $sscanf(line, "%s %h %h", tag, a, d);
        if (n >= 3 && (tag == "P" || tag == "D"))
            mem[a[9:2]] = d;
        if (n >= 3 && tag == "P")
            prog_words++;
    end
    $fclose(fd);
    return 1'b1;
endfunction

initial begin
    rst        = 1'b1;
    data_in    = '0;
    loaded     = 1'b0;
    prog_words = 0;
    if (!load_image()) begin
        $display("Could not read the golden file");
        $display("Test FAILED");
        $finish;
    end else begin
        loaded = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        wait (done);
        @(negedge clk);
        total_fails = fail_count + i_dut.i_arbiter.i_assert.error_count;
        $display("Stores matched: %0d, failed checks: %0d", pass_count, total_fails);
        if (total_fails == 0 && pass_count > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end
end

initial begin
    wait (loaded);
    repeat (CYCLES_PER_INST * prog_words) @(posedge clk);
    $display("Program did not reach the end marker within %0d cycles",
             CYCLES_PER_INST * prog_words);
    $display("Test FAILED");
    $finish;
end

endmodule

//--- include/rv_core_settings.svh
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// Width of a data word and of an instruction.
`define RV_XLEN 32

// Number of architectural integer registers.
`define RV_REG_CNT 32

// Address of the first instruction after reset.
`define RV_RESET_PC 32'h0000_0000

`endif

//--- rv_core.f
+incdir+include
verilog/rv_core_pkg.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_exec.sv
verilog/rv_writeback.sv
verilog/rv_mem_arbiter.sv
verilog/rv_core.sv
bench/rv_core_assert.sv
bench/rv_core_check.sv
bench/rv_core_tb.sv

//--- verilog/rv_core.sv
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_core import rv_core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`RV_XLEN-1:0]   data_in,
    output logic [`RV_XLEN-1:0]   data_out,
    output logic [`RV_XLEN-3:0]   addr,
    output logic [`RV_XLEN/8-1:0] wes
);

localparam int RW = $clog2(`RV_REG_CNT);

logic [`RV_XLEN-1:0] pc;

logic                fetch_en, fetch_ready, fetch_mem_req;
logic [`RV_XLEN-1:0] fetch_pc, fetch_mem_addr, fetch_inst;

logic                decode_en, decode_ready;
logic [`RV_XLEN-1:0] decode_inst, decode_pc, decode_imm;
opcode_e             decode_op;
logic [RW-1:0]       decode_rd, decode_rs1, decode_rs2;
logic [2:0]          decode_funct3;
logic [6:0]          decode_funct7;

logic                exec_en, exec_ready, exec_flush;
opcode_e             exec_op;
logic [`RV_XLEN-1:0] exec_pc, exec_rs1_val, exec_rs2_val, exec_imm;
logic [2:0]          exec_funct3;
logic [6:0]          exec_funct7;
logic [RW-1:0]       exec_rd;
logic                exec_mem_req, exec_mem_we;
logic [`RV_XLEN-1:0] exec_mem_addr, exec_mem_wdata, exec_result, exec_target;
acc_width_e          exec_mem_width;

logic                wb_en, wb_ready;
opcode_e             wb_op;
logic [2:0]          wb_funct3;
logic [RW-1:0]       wb_rd;
logic [`RV_XLEN-1:0] wb_val, rf_rs1_val, rf_rs2_val;
logic [1:0]          wb_byte_off;

logic [1:0]          mem_ready;
logic [`RV_XLEN-1:0] mem_rdata;

stage_state_e fetch_state, decode_state, exec_state, wb_state;
logic         fetch_start, decode_start, exec_start, wb_start;

rv_fetch i_fetch (
    .clk(clk), .rst(rst), .en(fetch_en), .pc(fetch_pc),
    .mem_data(mem_rdata), .mem_ready(mem_ready[0]),
    .mem_req(fetch_mem_req), .mem_addr(fetch_mem_addr),
    .inst(fetch_inst), .ready(fetch_ready)
);

rv_decode i_decode (
    .clk(clk), .en(decode_en), .inst(decode_inst), .op(decode_op),
    .rd(decode_rd), .rs1(decode_rs1), .rs2(decode_rs2),
    .funct3(decode_funct3), .funct7(decode_funct7),
    .imm(decode_imm), .ready(decode_ready)
);

rv_exec i_exec (
    .clk(clk), .en(exec_en), .op(exec_op), .pc(exec_pc),
    .rs1_val(exec_rs1_val), .rs2_val(exec_rs2_val), .imm(exec_imm),
    .funct3(exec_funct3), .funct7(exec_funct7),
    .mem_data(mem_rdata), .mem_ready(mem_ready[1]),
    .mem_req(exec_mem_req), .mem_we(exec_mem_we),
    .mem_addr(exec_mem_addr), .mem_wdata(exec_mem_wdata), .mem_width(exec_mem_width),
    .result(exec_result), .target(exec_target), .flush(exec_flush), .ready(exec_ready)
);

rv_writeback i_writeback (
    .clk(clk), .rst(rst), .en(wb_en), .op(wb_op), .funct3(wb_funct3),
    .rd(wb_rd), .val(wb_val), .byte_off(wb_byte_off),
    .rs1(decode_rs1), .rs2(decode_rs2),
    .rs1_val(rf_rs1_val), .rs2_val(rf_rs2_val), .ready(wb_ready)
);

rv_mem_arbiter i_arbiter (
    .clk(clk), .rst(rst), .data_in(data_in),
    .req({exec_mem_req, fetch_mem_req}),
    .c0_addr(fetch_mem_addr),
    .c1_addr(exec_mem_addr), .c1_we(exec_mem_we),
    .c1_width(exec_mem_width), .c1_wdata(exec_mem_wdata),
    .ready(mem_ready), .rdata(mem_rdata),
    .data_out(data_out), .addr(addr), .wes(wes)
);

assign fetch_state  = stage_state_e'({fetch_en, fetch_ready});
assign decode_state = stage_state_e'({decode_en, decode_ready});
assign exec_state   = stage_state_e'({exec_en, exec_ready});
assign wb_state     = stage_state_e'({wb_en, wb_ready});

assign fetch_start  = fetch_state == st_idle;
assign decode_start = fetch_state == st_complete &&
                      (decode_state == st_idle || decode_state == st_resetting);
// Exec reads its operands from the register file, so a write still in flight must land first.
assign exec_start   = decode_state == st_complete && wb_state != st_busy &&
                      (exec_state == st_idle || exec_state == st_resetting);
assign wb_start     = exec_state == st_complete &&
                      (wb_state == st_idle || wb_state == st_resetting);

always_ff @(posedge clk) begin
    if (rst) begin
        pc        <= `RV_RESET_PC;
        fetch_en  <= 1'b0;
        decode_en <= 1'b0;
        exec_en   <= 1'b0;
        wb_en     <= 1'b0;
    end else begin
        if (fetch_start) begin
            fetch_en <= 1'b1;
            fetch_pc <= pc;
        end
        if (decode_start) begin
            fetch_en    <= 1'b0;
            decode_en   <= 1'b1;
            decode_inst <= fetch_inst;
            decode_pc   <= fetch_pc;
            pc          <= pc + 4;
        end
        if (exec_start) begin
            decode_en    <= 1'b0;
            exec_en      <= 1'b1;
            exec_op      <= decode_op;
            exec_pc      <= decode_pc;
            exec_rd      <= decode_rd;
            exec_imm     <= decode_imm;
            exec_funct3  <= decode_funct3;
            exec_funct7  <= decode_funct7;
            exec_rs1_val <= rf_rs1_val;
            exec_rs2_val <= rf_rs2_val;
        end
        if (wb_start) begin
            exec_en     <= 1'b0;
            wb_en       <= 1'b1;
            wb_op       <= exec_op;
            wb_rd       <= exec_rd;
            wb_funct3   <= exec_funct3;
            wb_val      <= exec_result;
            wb_byte_off <= exec_mem_addr[1:0];
            // A taken jump or branch throws away whatever was fetched behind it.
            if (exec_flush) begin
                pc        <= exec_target;
                fetch_en  <= 1'b0;
                decode_en <= 1'b0;
            end
        end
        if (wb_state == st_complete)
            wb_en <= 1'b0;
    end
end

endmodule

//--- verilog/rv_core_pkg.sv
package rv_core_pkg;

// Major opcodes, taken from bits 6:0 of the instruction.
typedef enum logic [6:0] {
    op_lui     = 7'b0110111,
    op_auipc   = 7'b0010111,
    op_jal     = 7'b1101111,
    op_jalr    = 7'b1100111,
    op_load    = 7'b0000011,
    op_store   = 7'b0100011,
    op_branch  = 7'b1100011,
    op_int_imm = 7'b0010011,
    op_int     = 7'b0110011
} opcode_e;

// Stage state, encoded as {en, ready}.
typedef enum logic [1:0] {
    st_idle      = 2'b00,
    st_resetting = 2'b01,
    st_busy      = 2'b10,
    st_complete  = 2'b11
} stage_state_e;

typedef enum logic [1:0] {
    acc_8  = 2'b00,
    acc_16 = 2'b01,
    acc_32 = 2'b10
} acc_width_e;

endpackage

//--- verilog/rv_decode.sv
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_decode import rv_core_pkg::*; (
    input  logic                            clk,
    input  logic                            en,
    input  logic [`RV_XLEN-1:0]             inst,
    output opcode_e                         op,
    output logic [$clog2(`RV_REG_CNT)-1:0]  rd,
    output logic [$clog2(`RV_REG_CNT)-1:0]  rs1,
    output logic [$clog2(`RV_REG_CNT)-1:0]  rs2,
    output logic [2:0]                      funct3,
    output logic [6:0]                      funct7,
    output logic [`RV_XLEN-1:0]             imm,
    output logic                            ready
);

opcode_e             raw_op;
logic [`RV_XLEN-1:0] imm_sel;

// Opcodes outside the enum pass through and later act as no-ops.
assign raw_op = opcode_e'(inst[6:0]);

always_comb begin
    case (raw_op)
        op_jalr, op_load, op_int_imm:
            imm_sel = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
        op_store:
            imm_sel = {{(`RV_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
        op_branch:
            imm_sel = {{(`RV_XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        op_lui, op_auipc:
            imm_sel = {inst[31:12], 12'b0};
        op_jal:
            imm_sel = {{(`RV_XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        default:
            imm_sel = '0;
    endcase
end

always_ff @(posedge clk) begin
    ready <= en;
    if (en) begin
        op     <= raw_op;
        rd     <= inst[11:7];
        funct3 <= inst[14:12];
        rs1    <= inst[19:15];
        rs2    <= inst[24:20];
        funct7 <= inst[31:25];
        imm    <= imm_sel;
    end
end

endmodule

//--- verilog/rv_exec.sv
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_exec import rv_core_pkg::*; (
    input  logic                clk,
    input  logic                en,
    input  opcode_e             op,
    input  logic [`RV_XLEN-1:0] pc,
    input  logic [`RV_XLEN-1:0] rs1_val,
    input  logic [`RV_XLEN-1:0] rs2_val,
    input  logic [`RV_XLEN-1:0] imm,
    input  logic [2:0]          funct3,
    input  logic [6:0]          funct7,
    input  logic [`RV_XLEN-1:0] mem_data,
    input  logic                mem_ready,
    output logic                mem_req,
    output logic                mem_we,
    output logic [`RV_XLEN-1:0] mem_addr,
    output logic [`RV_XLEN-1:0] mem_wdata,
    output acc_width_e          mem_width,
    output logic [`RV_XLEN-1:0] result,
    output logic [`RV_XLEN-1:0] target,
    output logic                flush,
    output logic                ready
);

logic [`RV_XLEN-1:0] op_b;
logic [`RV_XLEN-1:0] ea;
logic [`RV_XLEN-1:0] alu_out;
logic [`RV_XLEN-1:0] result_next;
logic [4:0]          shamt;
logic                taken;
logic                is_mem;
logic                issued;
acc_width_e          width_next;

assign op_b   = (op == op_int) ? rs2_val : imm;
assign shamt  = op_b[4:0];
assign ea     = rs1_val + imm;
assign is_mem = (op == op_load) || (op == op_store);

always_comb begin
    case (funct3)
        3'b000: begin
            if (op == op_int && funct7[5])
                alu_out = rs1_val - op_b;
            else
                alu_out = rs1_val + op_b;
        end
        3'b001: alu_out = rs1_val << shamt;
        3'b010: alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(rs1_val) < $signed(op_b)};
        3'b011: alu_out = {{(`RV_XLEN-1){1'b0}}, rs1_val < op_b};
        3'b100: alu_out = rs1_val ^ op_b;
        3'b101: begin
            // Instruction bit 30 picks the arithmetic shift, for SRA and SRAI alike.
            if (funct7[5])
                alu_out = $signed(rs1_val) >>> shamt;
            else
                alu_out = rs1_val >> shamt;
        end
        3'b110: alu_out = rs1_val | op_b;
        default: alu_out = rs1_val & op_b;
    endcase
end

always_comb begin
    case (funct3)
        3'b000: taken = rs1_val == rs2_val;
        3'b001: taken = rs1_val != rs2_val;
        3'b100: taken = $signed(rs1_val) < $signed(rs2_val);
        3'b101: taken = $signed(rs1_val) >= $signed(rs2_val);
        3'b110: taken = rs1_val < rs2_val;
        3'b111: taken = rs1_val >= rs2_val;
        default: taken = 1'b0;
    endcase
end

always_comb begin
    case (op)
        op_lui:             result_next = imm;
        op_auipc:           result_next = pc + imm;
        op_jal, op_jalr:    result_next = pc + 4;
        op_int_imm, op_int: result_next = alu_out;
        default:            result_next = '0;
    endcase
    case (funct3[1:0])
        2'b00:   width_next = acc_8;
        2'b01:   width_next = acc_16;
        default: width_next = acc_32;
    endcase
end

always_ff @(posedge clk) begin
    if (!en) begin
        issued  <= 1'b0;
        mem_req <= 1'b0;
        ready   <= 1'b0;
    end else if (!issued) begin
        issued    <= 1'b1;
        result    <= result_next;
        flush     <= (op == op_jal) || (op == op_jalr) || (op == op_branch && taken);
        target    <= (op == op_jalr) ? {ea[`RV_XLEN-1:1], 1'b0} : pc + imm;
        mem_addr  <= ea;
        mem_wdata <= rs2_val;
        mem_we    <= op == op_store;
        mem_width <= width_next;
        mem_req   <= is_mem;
        ready     <= !is_mem;
    end else if (mem_req && mem_ready) begin
        mem_req <= 1'b0;
        ready   <= 1'b1;
        // Writeback picks the byte or half out of the raw word.
        if (!mem_we)
            result <= mem_data;
    end
end

endmodule

//--- verilog/rv_fetch.sv
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_fetch (
    input  logic                clk,
    input  logic                rst,
    input  logic                en,
    input  logic [`RV_XLEN-1:0] pc,
    input  logic [`RV_XLEN-1:0] mem_data,
    input  logic                mem_ready,
    output logic                mem_req,
    output logic [`RV_XLEN-1:0] mem_addr,
    output logic [`RV_XLEN-1:0] inst,
    output logic                ready
);

// A request started before a flush still runs to completion on the bus,
// but issued is cleared when en falls, so its word is dropped.
logic issued;
logic hit;

assign hit = mem_req && mem_ready && issued;

always_ff @(posedge clk) begin
    if (rst) begin
        mem_req <= 1'b0;
        issued  <= 1'b0;
        ready   <= 1'b0;
    end else begin
        ready <= en && (ready || hit);
        if (mem_req) begin
            if (mem_ready)
                mem_req <= 1'b0;
        end else if (en && !issued) begin
            mem_req <= 1'b1;
            issued  <= 1'b1;
        end
        if (!en)
            issued <= 1'b0;
    end
end

always_ff @(posedge clk) begin
    if (en && !issued && !mem_req)
        mem_addr <= pc;
    if (hit)
        inst <= mem_data;
end

endmodule

//--- verilog/rv_mem_arbiter.sv
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_mem_arbiter import rv_core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`RV_XLEN-1:0]   data_in,
    input  logic [1:0]            req,
    input  logic [`RV_XLEN-1:0]   c0_addr,
    input  logic [`RV_XLEN-1:0]   c1_addr,
    input  logic                  c1_we,
    input  acc_width_e            c1_width,
    input  logic [`RV_XLEN-1:0]   c1_wdata,
    output logic [1:0]            ready,
    output logic [`RV_XLEN-1:0]   rdata,
    output logic [`RV_XLEN-1:0]   data_out,
    output logic [`RV_XLEN-3:0]   addr,
    output logic [`RV_XLEN/8-1:0] wes
);

logic [1:0]            grant;
logic [`RV_XLEN/8-1:0] lane_mask;

// No new grant while a read returns, since the served client still holds req.
always_comb begin
    grant = 2'b00;
    if (ready == 2'b00) begin
        if (req[1])
            grant = 2'b10;
        else if (req[0])
            grant = 2'b01;
    end
end

always_comb begin
    case (c1_width)
        acc_8: begin
            lane_mask = 4'b0001 << c1_addr[1:0];
            data_out  = {4{c1_wdata[7:0]}};
        end
        acc_16: begin
            lane_mask = c1_addr[1] ? 4'b1100 : 4'b0011;
            data_out  = {2{c1_wdata[15:0]}};
        end
        default: begin
            lane_mask = 4'b1111;
            data_out  = c1_wdata;
        end
    endcase
end

assign addr  = grant[1] ? c1_addr[`RV_XLEN-1:2] : c0_addr[`RV_XLEN-1:2];
assign wes   = (grant[1] && c1_we) ? lane_mask : '0;
assign rdata = data_in;

always_ff @(posedge clk) begin
    if (rst)
        ready <= 2'b00;
    else
        ready <= grant;
end

endmodule

//--- verilog/rv_writeback.sv
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_writeback import rv_core_pkg::*; (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           en,
    input  opcode_e                        op,
    input  logic [2:0]                     funct3,
    input  logic [$clog2(`RV_REG_CNT)-1:0] rd,
    input  logic [`RV_XLEN-1:0]            val,
    input  logic [1:0]                     byte_off,
    input  logic [$clog2(`RV_REG_CNT)-1:0] rs1,
    input  logic [$clog2(`RV_REG_CNT)-1:0] rs2,
    output logic [`RV_XLEN-1:0]            rs1_val,
    output logic [`RV_XLEN-1:0]            rs2_val,
    output logic                           ready
);

logic [`RV_XLEN-1:0] regs [`RV_REG_CNT];
logic [`RV_XLEN-1:0] wdata;
logic [7:0]          ld_byte;
logic [15:0]         ld_half;
logic                writes;

assign ld_byte = val[{byte_off, 3'b000} +: 8];
assign ld_half = byte_off[1] ? val[31:16] : val[15:0];

always_comb begin
    wdata = val;
    if (op == op_load) begin
        case (funct3)
            3'b000:  wdata = {{(`RV_XLEN-8){ld_byte[7]}}, ld_byte};
            3'b001:  wdata = {{(`RV_XLEN-16){ld_half[15]}}, ld_half};
            3'b100:  wdata = {{(`RV_XLEN-8){1'b0}}, ld_byte};
            3'b101:  wdata = {{(`RV_XLEN-16){1'b0}}, ld_half};
            default: wdata = val;
        endcase
    end
    case (op)
        op_lui, op_auipc, op_jal, op_jalr, op_load, op_int_imm, op_int:
            writes = rd != '0;
        default:
            writes = 1'b0;
    endcase
end

// Entry 0 is cleared at reset and never written, so x0 always reads zero.
assign rs1_val = regs[rs1];
assign rs2_val = regs[rs2];

always_ff @(posedge clk) begin
    if (rst) begin
        for (int i = 0; i < `RV_REG_CNT; i++)
            regs[i] <= '0;
        ready <= 1'b0;
    end else begin
        ready <= en;
        if (en && !ready && writes)
            regs[rd] <= wdata;
    end
end

endmodule
